// ==== source/pantry_config.svh ====
`ifndef PANTRY_CONFIG_SVH
`define PANTRY_CONFIG_SVH

// Number of range_check units in the chain, which is also the most ranges one problem can use
`define PANTRY_UNITS 8

// Width of an ingredient ID and of a range bound
`define PANTRY_ID_WIDTH 16

// Width of the ID counters in fresh_counter
`define PANTRY_COUNT_WIDTH 16

`endif

// ==== source/pantry_pkg.sv ====
`include "pantry_config.svh"

package pantry_pkg;

    // An ingredient ID or one bound of a range
    typedef logic [`PANTRY_ID_WIDTH-1:0] id_t;

    // Number of IDs seen in one problem
    typedef logic [`PANTRY_COUNT_WIDTH-1:0] count_t;

    // One word on the chain
    // is_id is 1 for an ingredient ID and 0 for a range bound
    // last marks the final ID of a problem and survives even when that ID is dropped
    typedef struct packed {
        logic valid;
        logic is_id;
        logic last;
        id_t  data;
    } item_t;

    // A unit first collects its own range, then passes later ranges on,
    // and finally filters IDs until the last marker goes by
    typedef enum logic [1:0] {
        wait_lower,
        wait_upper,
        pass_ranges,
        filter_ids
    } unit_state_t;

endpackage

// ==== source/range_check.sv ====
`timescale 1ns/1ns

module range_check (
    input  wire               clk,
    input  wire               rst_n,
    // From the previous unit, or from the chain input for the first unit
    input  pantry_pkg::item_t up_item,
    // Towards the next unit, or to the counter after the final unit
    output pantry_pkg::item_t down_item
);

    // With the lower bound above the upper bound no ID can fall inside the range
    localparam pantry_pkg::id_t empty_lower = '1;
    localparam pantry_pkg::id_t empty_upper = '0;

    pantry_pkg::unit_state_t state;
    pantry_pkg::unit_state_t state_next;

    pantry_pkg::id_t lower_bound;
    pantry_pkg::id_t upper_bound;

    pantry_pkg::item_t item_next;

    logic bound_in;
    logic id_in;
    logic last_in;
    logic outside;

    assign bound_in = up_item.valid && !up_item.is_id;

    // An ID dropped further up still arrives as a marker with valid low.
    // Only a real ID or the last marker is taken as the start of the ID phase
    assign id_in = up_item.is_id && (up_item.valid || up_item.last);

    assign last_in = up_item.is_id && up_item.last;

    assign outside = (up_item.data < lower_bound) || (up_item.data > upper_bound);

    always_comb begin: state_logic
        state_next = state;
        if (last_in) begin
            // The last marker ends the problem and readies the unit for the next ranges
            state_next = pantry_pkg::wait_lower;
        end else if (id_in) begin
            state_next = pantry_pkg::filter_ids;
        end else if (bound_in) begin
            case (state)
                pantry_pkg::wait_lower: begin
                    state_next = pantry_pkg::wait_upper;
                end
                pantry_pkg::wait_upper: begin
                    state_next = pantry_pkg::pass_ranges;
                end
                default: begin
                    state_next = state;
                end
            endcase
        end
    end

    always_comb begin: output_logic
        item_next = up_item;
        if (up_item.is_id) begin
            // is_id and last go on unchanged, only valid is filtered
            item_next.valid = up_item.valid && outside;
        end else if (state != pantry_pkg::pass_ranges) begin
            // This unit keeps the bound for itself
            item_next.valid = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin: state_register
        if (!rst_n) begin
            state <= pantry_pkg::wait_lower;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin: bound_register
        if (!rst_n) begin
            lower_bound <= empty_lower;
            upper_bound <= empty_upper;
        end else if (last_in) begin
            lower_bound <= empty_lower;
            upper_bound <= empty_upper;
        end else if (bound_in && (state == pantry_pkg::wait_lower)) begin
            lower_bound <= up_item.data;
        end else if (bound_in && (state == pantry_pkg::wait_upper)) begin
            upper_bound <= up_item.data;
        end
    end

    // One register stage per unit
    always_ff @(posedge clk or negedge rst_n) begin: output_register
        if (!rst_n) begin
            down_item <= '0;
        end else begin
            down_item <= item_next;
        end
    end

    // Nothing leaves the unit straight out of reset
    a_reset_idle: assert property (
        @(posedge clk) !rst_n |=> !down_item.valid
    ) else $error("range_check: valid output in the cycle after reset");

    // Outside the capture states the range only changes when a last marker clears it
    a_bounds_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(state inside {pantry_pkg::wait_lower, pantry_pkg::wait_upper}) && !last_in
        |=> $stable(lower_bound) && $stable(upper_bound)
    ) else $error("range_check: bounds changed outside the capture states");

    // An ID that comes out valid was outside the range held when it went in
    a_kept_outside: assert property (
        @(posedge clk) disable iff (!rst_n)
        down_item.valid && down_item.is_id
        |-> (down_item.data < $past(lower_bound)) || (down_item.data > $past(upper_bound))
    ) else $error("range_check: forwarded ID %0d lies inside the range", down_item.data);

endmodule

// ==== source/fresh_counter.sv ====
`timescale 1ns/1ns
`include "pantry_config.svh"

module fresh_counter (
    input  wire                clk,
    input  wire                rst_n,
    // Chain input, seen at the same time as the first unit
    input  pantry_pkg::item_t  in_item,
    // Output of the final unit
    input  pantry_pkg::item_t  out_item,
    output pantry_pkg::count_t fresh_count,
    output logic               done,
    output logic               overflow
);

    // Copy of the chain input, delayed to match the latency of the units
    pantry_pkg::item_t in_delay [`PANTRY_UNITS];
    pantry_pkg::item_t in_aligned;

    pantry_pkg::count_t in_count;
    pantry_pkg::count_t out_count;

    logic in_hit;
    logic out_hit;
    logic out_last;
    logic out_bound;
    logic end_seen;

    always_ff @(posedge clk or negedge rst_n) begin: input_delay
        if (!rst_n) begin
            for (int i = 0; i < `PANTRY_UNITS; i++) begin
                in_delay[i] <= '0;
            end
        end else begin
            in_delay[0] <= in_item;
            for (int i = 1; i < `PANTRY_UNITS; i++) begin
                in_delay[i] <= in_delay[i-1];
            end
        end
    end

    assign in_aligned = in_delay[`PANTRY_UNITS-1];

    // in_aligned and out_item now show the same item of the stream in the same cycle
    assign in_hit = in_aligned.valid && in_aligned.is_id;
    assign out_hit = out_item.valid && out_item.is_id;

    // The marker arrives even when its ID was dropped inside the chain
    assign out_last = out_item.is_id && out_item.last;

    // A bound only gets through when every unit already holds a range
    assign out_bound = out_item.valid && !out_item.is_id;

    always_ff @(posedge clk or negedge rst_n) begin: id_counters
        if (!rst_n) begin
            in_count <= '0;
            out_count <= '0;
            end_seen <= 1'b0;
        end else begin
            end_seen <= out_last;
            if (end_seen) begin
                // While the totals are reported the next problem starts from what arrives now
                in_count <= pantry_pkg::count_t'(in_hit);
                out_count <= pantry_pkg::count_t'(out_hit);
            end else begin
                in_count <= in_count + pantry_pkg::count_t'(in_hit);
                out_count <= out_count + pantry_pkg::count_t'(out_hit);
            end
        end
    end

    // Every ID that did not come out was dropped by some unit, so it was fresh
    always_ff @(posedge clk or negedge rst_n) begin: result_register
        if (!rst_n) begin
            fresh_count <= '0;
            done <= 1'b0;
        end else begin
            done <= end_seen;
            if (end_seen) begin
                fresh_count <= in_count - out_count;
            end
        end
    end

    // Held through the done cycle so it can be read together with the count
    always_ff @(posedge clk or negedge rst_n) begin: overflow_flag
        if (!rst_n) begin
            overflow <= 1'b0;
        end else begin
            overflow <= out_bound || (overflow && !done);
        end
    end

    // The chain can only remove IDs, never add them
    a_out_not_above_in: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_count <= in_count
    ) else $error("fresh_counter: %0d IDs left the chain but only %0d went in",
                  out_count, in_count);

endmodule

// ==== source/pantry_filter.sv ====
`timescale 1ns/1ns
`include "pantry_config.svh"

module pantry_filter (
    input  wire                clk,
    input  wire                rst_n,
    // Ranges first as lower and upper bound pairs, then the IDs of the problem
    input  pantry_pkg::item_t  in_item,
    output pantry_pkg::count_t fresh_count,
    output logic               done,
    output logic               overflow
);

    // Entry k feeds unit k, the final entry goes to the counter
    pantry_pkg::item_t chain [`PANTRY_UNITS+1];

    assign chain[0] = in_item;

    generate
        for (genvar k = 0; k < `PANTRY_UNITS; k++) begin: g_unit
            range_check i_range_check (
                .clk       (clk),
                .rst_n     (rst_n),
                .up_item   (chain[k]),
                .down_item (chain[k+1])
            );
        end
    endgenerate

    // Compares what went into the chain with what survived it
    fresh_counter i_fresh_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_item     (in_item),
        .out_item    (chain[`PANTRY_UNITS]),
        .fresh_count (fresh_count),
        .done        (done),
        .overflow    (overflow)
    );

endmodule

// ==== tests/pantry_filter_tb.sv ====
`timescale 1ns/1ns
`include "pantry_config.svh"

module pantry_filter_tb;

    // Longest wait for done after the last ID has been driven
    localparam int done_timeout = 4 * `PANTRY_UNITS + 16;

    // The edge after the drive samples the last ID and done rises PANTRY_UNITS+1 edges later,
    // so done is first seen at this falling edge counted from the drive
    localparam int done_latency = `PANTRY_UNITS + 2;

    logic clk;
    logic rst_n;
    pantry_pkg::item_t in_item;
    pantry_pkg::count_t fresh_count;
    logic done;
    logic overflow;

    // The problem being built, used both for stimulus and for the model
    pantry_pkg::id_t range_lo [$];
    pantry_pkg::id_t range_hi [$];
    pantry_pkg::id_t ids [$];

    logic [31:0] rng_state;
    int error_count;
    int test_count;

    pantry_filter i_pantry_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_item     (in_item),
        .fresh_count (fresh_count),
        .done        (done),
        .overflow    (overflow)
    );

    initial begin: clock_gen
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // An ID is fresh when it lies inside any of the first range_limit ranges
    function automatic int model_fresh(input int range_limit);
        int fresh;
        int used;
        logic hit;
        fresh = 0;
        used = (range_lo.size() < range_limit) ? range_lo.size() : range_limit;
        foreach (ids[i]) begin
            hit = 1'b0;
            for (int r = 0; r < used; r++) begin
                if ((ids[i] >= range_lo[r]) && (ids[i] <= range_hi[r])) begin
                    hit = 1'b1;
                end
            end
            if (hit) begin
                fresh++;
            end
        end
        return fresh;
    endfunction

    task automatic clear_problem();
        range_lo.delete();
        range_hi.delete();
        ids.delete();
    endtask

    task automatic add_range(input pantry_pkg::id_t lo, input pantry_pkg::id_t hi);
        range_lo.push_back(lo);
        range_hi.push_back(hi);
    endtask

    task automatic add_id(input pantry_pkg::id_t id);
        ids.push_back(id);
    endtask

    task automatic drive_item(input logic is_id, input logic last, input pantry_pkg::id_t data);
        @(negedge clk);
        in_item.valid = 1'b1;
        in_item.is_id = is_id;
        in_item.last = last;
        in_item.data = data;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        in_item = '0;
    endtask

    task automatic insert_gap(input int max_gap);
        int n;
        n = 0;
        if (max_gap > 0) begin
            n = next_random() % (max_gap + 1);
        end
        repeat (n) begin
            drive_idle();
        end
    endtask

    // Bounds first, lower then upper, then the IDs with last on the final one
    task automatic send_problem(input int max_gap);
        for (int r = 0; r < range_lo.size(); r++) begin
            drive_item(1'b0, 1'b0, range_lo[r]);
            insert_gap(max_gap);
            drive_item(1'b0, 1'b0, range_hi[r]);
            insert_gap(max_gap);
        end
        for (int i = 0; i < ids.size(); i++) begin
            drive_item(1'b1, i == ids.size() - 1, ids[i]);
            if (i < ids.size() - 1) begin
                insert_gap(max_gap);
            end
        end
    endtask

    // Counts falling edges from the drive of the last ID until done is seen
    task automatic wait_for_done(output bit got_done, output int cycles);
        got_done = 1'b0;
        cycles = 0;
        while (!got_done && (cycles < done_timeout)) begin
            @(negedge clk);
            in_item = '0;
            cycles++;
            got_done = done;
        end
        assert (got_done) else begin
            $display("done did not arrive within %0d cycles after the last ID", done_timeout);
            error_count++;
        end
    endtask

    // Called in the done cycle, while fresh_count and overflow are stable
    task automatic check_result();
        pantry_pkg::count_t expected_count;
        logic expected_overflow;
        expected_count = pantry_pkg::count_t'(model_fresh(`PANTRY_UNITS));
        expected_overflow = (range_lo.size() > `PANTRY_UNITS);
        assert (fresh_count == expected_count) else begin
            $display("FAIL fresh_count: got 0x%h, expected 0x%h", fresh_count, expected_count);
            error_count++;
        end
        assert (overflow == expected_overflow) else begin
            $display("FAIL overflow: got 0x%h, expected 0x%h", overflow, expected_overflow);
            error_count++;
        end
    endtask

    task automatic run_problem(input int max_gap, output int latency);
        bit got_done;
        send_problem(max_gap);
        wait_for_done(got_done, latency);
        if (got_done) begin
            check_result();
        end
    endtask

    task automatic report_test(input int number, input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", number, name);
        end else begin
            $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
        end
    endtask

    task automatic disjoint_ranges();
        int errors_before;
        int latency;
        errors_before = error_count;
        clear_problem();
        add_range(16'd100, 16'd199);
        add_range(16'd300, 16'd349);
        add_range(16'd500, 16'd520);
        add_id(16'd100);
        add_id(16'd150);
        add_id(16'd199);
        add_id(16'd99);
        add_id(16'd200);
        add_id(16'd300);
        add_id(16'd320);
        add_id(16'd349);
        add_id(16'd299);
        add_id(16'd350);
        add_id(16'd500);
        add_id(16'd499);
        add_id(16'd510);
        add_id(16'd520);
        add_id(16'd521);
        add_id(16'd0);
        add_id(16'hffff);
        run_problem(0, latency);
        report_test(1, "disjoint ranges", errors_before);
    endtask

    task automatic overlap_and_point();
        int errors_before;
        int latency;
        errors_before = error_count;
        clear_problem();
        add_range(16'd10, 16'd20);
        add_range(16'd15, 16'd25);
        // Single-point range
        add_range(16'd40, 16'd40);
        add_id(16'd15);
        add_id(16'd18);
        add_id(16'd20);
        add_id(16'd25);
        add_id(16'd26);
        add_id(16'd9);
        add_id(16'd39);
        add_id(16'd40);
        add_id(16'd41);
        run_problem(0, latency);
        report_test(2, "overlapping and single-point ranges", errors_before);
    endtask

    task automatic back_to_back();
        int errors_before;
        int latency;
        errors_before = error_count;
        clear_problem();
        add_range(16'd1000, 16'd1099);
        add_range(16'd2000, 16'd2009);
        add_id(16'd1000);
        add_id(16'd1050);
        add_id(16'd2005);
        add_id(16'd3000);
        run_problem(0, latency);
        // These IDs would be fresh if the first ranges were still held
        clear_problem();
        add_range(16'd3000, 16'd3010);
        add_id(16'd1050);
        add_id(16'd2005);
        add_id(16'd3000);
        add_id(16'd3010);
        add_id(16'd3011);
        run_problem(0, latency);
        report_test(3, "back-to-back problems", errors_before);
    endtask

    task automatic full_chain_overflow();
        int errors_before;
        int latency;
        errors_before = error_count;
        clear_problem();
        for (int k = 0; k < `PANTRY_UNITS; k++) begin
            add_range(pantry_pkg::id_t'(100 * k), pantry_pkg::id_t'(100 * k + 10));
            add_id(pantry_pkg::id_t'(100 * k + 5));
            add_id(pantry_pkg::id_t'(100 * k + 50));
        end
        run_problem(0, latency);
        // One range more than the chain holds, so 9005 is spoiled for the DUT
        add_range(16'd9000, 16'd9010);
        add_id(16'd9005);
        run_problem(0, latency);
        report_test(4, "full chain and overflow", errors_before);
    endtask

    task automatic random_stream();
        int errors_before;
        int latency;
        pantry_pkg::id_t a;
        pantry_pkg::id_t b;
        errors_before = error_count;
        clear_problem();
        for (int k = 0; k < 5; k++) begin
            a = pantry_pkg::id_t'(next_random() % 1000);
            b = pantry_pkg::id_t'(next_random() % 1000);
            if (a <= b) begin
                add_range(a, b);
            end else begin
                add_range(b, a);
            end
        end
        for (int i = 0; i < 40; i++) begin
            add_id(pantry_pkg::id_t'(next_random() % 1200));
        end
        run_problem(2, latency);
        assert (latency == done_latency) else begin
            $display("FAIL done latency: got 0x%h, expected 0x%h", latency, done_latency);
            error_count++;
        end
        report_test(5, "random IDs and ranges", errors_before);
    endtask

    task automatic ids_without_ranges();
        int errors_before;
        int latency;
        errors_before = error_count;
        clear_problem();
        add_id(16'd0);
        add_id(16'd5);
        add_id(16'd1000);
        add_id(16'hffff);
        run_problem(0, latency);
        report_test(6, "IDs without ranges", errors_before);
    endtask

    initial begin: main
        rst_n = 1'b0;
        in_item = '0;
        rng_state = 32'h4712bafb;
        error_count = 0;
        test_count = 0;
        repeat (16) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;

        disjoint_ranges();
        overlap_and_point();
        back_to_back();
        full_chain_overflow();
        random_stream();
        ids_without_ranges();

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== pantry_filter.f ====
+incdir+source
source/pantry_pkg.sv
source/range_check.sv
source/fresh_counter.sv
source/pantry_filter.sv
tests/pantry_filter_tb.sv
